// ==== src/hbridge_pkg.sv ====
package hbridge_pkg;

   // ==================================================
   // tank adc samples
   // ==================================================
   localparam int SAMPLE_W     = 14;
   // offset-binary centre for the scope dacs
   localparam int DAC_MIDSCALE = 8191;

   // ==================================================
   // bridge and start-up
   // ==================================================
   // bit order: s1 leg1 high, s2 leg2 high, s3 leg1 low, s4 leg2 low
   localparam int N_SWITCH = 4;
   localparam logic [N_SWITCH-1:0] BOOTSTRAP_PATTERN = 4'b1100;
   // s1 + s4, drives sigma to one
   localparam logic [N_SWITCH-1:0] FORCED_PATTERN    = 4'b1001;
   // one tick is 1 us on the board, shortened here
   localparam int TICK_CYCLES = 4;
   localparam int ON_TICKS    = 10;
   localparam int VG_TICKS    = 16;

   // dead time, indexed by select code
   localparam int DT_SEL_W = 2;
   localparam int DT_CNT_W = 4;
   localparam logic [DT_CNT_W-1:0] DT_TABLE [2**DT_SEL_W] = '{8, 4, 2, 6};

   // angle setpoints
   localparam int ANGLE_W    = 8;
   localparam int PHI_STEP   = 5;
   localparam int PHI_MAX    = 90;
   localparam int DELTA_STEP = 1;
   localparam int DELTA_MAX  = 40;

   // active-low segments, bit 7 is the dot (kept off)
   function automatic logic [7:0] seg_digit(input logic [3:0] digit);
      case (digit)
         4'd0:    return 8'hc0;
         4'd1:    return 8'hf9;
         4'd2:    return 8'ha4;
         4'd3:    return 8'hb0;
         4'd4:    return 8'h99;
         4'd5:    return 8'h92;
         4'd6:    return 8'h82;
         4'd7:    return 8'hf8;
         4'd8:    return 8'h80;
         4'd9:    return 8'h90;
         // out of range shows a dash
         default: return 8'hbf;
      endcase
   endfunction

endpackage

// ==== src/sample_capture.sv ====
`timescale 1ns/1ps

module sample_capture (
   input  logic                                   ADA_DCO,
   input  logic                                   i_rst_n,
   input  logic signed [hbridge_pkg::SAMPLE_W-1:0] i_ada_data,
   input  logic signed [hbridge_pkg::SAMPLE_W-1:0] i_adb_data,
   output logic signed [hbridge_pkg::SAMPLE_W-1:0] o_adc_a,
   output logic signed [hbridge_pkg::SAMPLE_W-1:0] o_adc_b,
   output logic        [hbridge_pkg::SAMPLE_W-1:0] o_da,
   output logic        [hbridge_pkg::SAMPLE_W-1:0] o_db
);
   import hbridge_pkg::*;

   logic signed [SAMPLE_W-1:0] neg_a;
   logic signed [SAMPLE_W-1:0] neg_b;

   // tank sensors have inverted polarity
   assign neg_a   = -i_ada_data;
   assign neg_b   = -i_adb_data;

   // one register stage
   always_ff @(posedge ADA_DCO) begin
      if (!i_rst_n) begin
         o_adc_a <= '0;
         o_adc_b <= '0;
         o_da    <= '0;
         o_db    <= '0;
      end else begin
         o_adc_a <= neg_a;
         o_adc_b <= neg_b;
         // dac copy wraps at 14 bits
         o_da    <= $unsigned(neg_a) + SAMPLE_W'(DAC_MIDSCALE);
         o_db    <= $unsigned(neg_b) + SAMPLE_W'(DAC_MIDSCALE);
      end
   end

endmodule

// ==== src/dead_time.sv ====
`timescale 1ns/1ps

module dead_time (
   input  logic                               ADA_DCO,
   input  logic                               i_rst_n,
   input  logic [hbridge_pkg::N_SWITCH-1:0]   i_cmd,
   input  logic [hbridge_pkg::DT_SEL_W-1:0]   i_dt_sel,
   output logic [hbridge_pkg::N_SWITCH-1:0]   o_delayed
);
   import hbridge_pkg::*;

   // ==================================================
   // per-switch turn-on delay
   // ==================================================

   // cycles the command has been high in a row
   logic [DT_CNT_W-1:0] on_cnt [N_SWITCH];
   logic [DT_CNT_W-1:0] dt_target;

   // select sampled every cycle
   assign dt_target = DT_TABLE[i_dt_sel];

   always_ff @(posedge ADA_DCO) begin
      if (!i_rst_n) begin
         for (int i = 0; i < N_SWITCH; i++) begin
            on_cnt[i] <= '0;
         end
      end else begin
         for (int i = 0; i < N_SWITCH; i++) begin
            // low command restarts the count
            if (!i_cmd[i]) begin
               on_cnt[i] <= '0;
            end else if (on_cnt[i] < dt_target) begin
               on_cnt[i] <= on_cnt[i] + 1'b1;
            end
         end
      end
   end

   // rise once the count reached the target, fall right away
   // once high, a later select change leaves the switch on
   always_ff @(posedge ADA_DCO) begin
      if (!i_rst_n) begin
         o_delayed <= '0;
      end else begin
         for (int i = 0; i < N_SWITCH; i++) begin
            o_delayed[i] <= i_cmd[i] & (o_delayed[i] | (on_cnt[i] >= dt_target));
         end
      end
   end

   // short pulses never reach the target
   // so the partner switch always gets its off time

endmodule

// ==== src/bridge_sequencer.sv ====
`timescale 1ns/1ps

module bridge_sequencer (
   input  logic                               ADA_DCO,
   input  logic                               i_rst_n,
   input  logic                               i_enable,
   input  logic [hbridge_pkg::N_SWITCH-1:0]   i_delayed,
   output logic [hbridge_pkg::N_SWITCH-1:0]   o_gate,
   output logic                               o_converter_on
);
   import hbridge_pkg::*;

   // tick prescaler and start-up tick count
   logic [$clog2(TICK_CYCLES)-1:0] presc;
   logic [$clog2(VG_TICKS+2)-1:0]  tick_cnt;
   logic                           tick;
   logic                           past_boot;
   logic                           past_vg;
   logic                           leg_short;

   assign tick      = (presc == $bits(presc)'(TICK_CYCLES - 1));
   assign past_boot = (tick_cnt > ON_TICKS);
   assign past_vg   = (tick_cnt > VG_TICKS);
   // s1+s3 shorts leg 1, s2+s4 shorts leg 2
   assign leg_short = (i_delayed[0] & i_delayed[2]) | (i_delayed[1] & i_delayed[3]);

   // ==================================================
   // start-up count
   // ==================================================
   always_ff @(posedge ADA_DCO) begin
      if (!i_rst_n || !i_enable) begin
         // held at zero, sequence restarts on next enable
         presc    <= '0;
         tick_cnt <= '0;
      end else begin
         if (tick) begin
            presc <= '0;
         end else begin
            presc <= presc + 1'b1;
         end
         // count freezes once past the forced phase
         if (tick && !past_vg) begin
            tick_cnt <= tick_cnt + 1'b1;
         end
      end
   end

   // ==================================================
   // gate select, registered
   // ==================================================
   always_ff @(posedge ADA_DCO) begin
      if (!i_rst_n) begin
         o_gate         <= '0;
         o_converter_on <= 1'b0;
      end else begin
         o_converter_on <= i_enable & past_boot;
         if (!i_enable) begin
            o_gate <= '0;
         end else if (!past_boot) begin
            // charge bootstrap caps through low sides
            o_gate <= BOOTSTRAP_PATTERN;
         end else if (!past_vg) begin
            o_gate <= FORCED_PATTERN;
         end else if (leg_short) begin
            o_gate <= '0;
         end else begin
            o_gate <= i_delayed;
         end
      end
   end

endmodule

// ==== src/angle_setpoint.sv ====
`timescale 1ns/1ps

module angle_setpoint #(
   parameter int STEP = 1,
   parameter int MAX  = 99
) (
   input  logic                              ADA_DCO,
   input  logic                              i_rst_n,
   input  logic                              i_inc,
   input  logic                              i_dec,
   input  logic                              i_zero,
   output logic [hbridge_pkg::ANGLE_W-1:0]   o_value,
   output logic [7:0]                        o_seg_ones,
   output logic [7:0]                        o_seg_tens
);
   import hbridge_pkg::*;

   // previous button levels
   logic                inc_q;
   logic                dec_q;
   logic                zero_q;
   logic                inc_edge;
   logic                dec_edge;
   logic                zero_edge;
   logic [ANGLE_W-1:0]  next_value;
   logic [ANGLE_W-1:0]  tens;
   logic [ANGLE_W-1:0]  ones;

   assign inc_edge  = i_inc & ~inc_q;
   assign dec_edge  = i_dec & ~dec_q;
   assign zero_edge = i_zero & ~zero_q;

   // ==================================================
   // saturating update
   // ==================================================
   always_comb begin
      next_value = o_value;
      if (zero_edge) begin
         next_value = '0;
      end else if (inc_edge) begin
         if (int'(o_value) + STEP > MAX) next_value = ANGLE_W'(MAX);
         else next_value = o_value + ANGLE_W'(STEP);
      end else if (dec_edge) begin
         // floor at zero
         if (int'(o_value) < STEP) next_value = '0;
         else next_value = o_value - ANGLE_W'(STEP);
      end
   end

   always_ff @(posedge ADA_DCO) begin
      if (!i_rst_n) begin
         inc_q   <= 1'b0;
         dec_q   <= 1'b0;
         zero_q  <= 1'b0;
         o_value <= '0;
      end else begin
         inc_q   <= i_inc;
         dec_q   <= i_dec;
         zero_q  <= i_zero;
         o_value <= next_value;
      end
   end

   // decimal split for the two digits
   assign tens       = o_value / ANGLE_W'(10);
   assign ones       = o_value % ANGLE_W'(10);
   assign o_seg_tens = seg_digit(tens[3:0]);
   assign o_seg_ones = seg_digit(ones[3:0]);

endmodule

// ==== src/converter_top.sv ====
`timescale 1ns/1ps

module converter_top (
   input  logic                                   ADA_DCO,
   input  logic                                   i_rst_n,
   input  logic signed [hbridge_pkg::SAMPLE_W-1:0] i_ada_data,
   input  logic signed [hbridge_pkg::SAMPLE_W-1:0] i_adb_data,
   input  logic        [hbridge_pkg::N_SWITCH-1:0] i_bridge_cmd,
   input  logic        [3:0]                      i_sw,
   input  logic        [3:0]                      i_button,
   input  logic        [hbridge_pkg::DT_SEL_W-1:0] i_dsw_dt,
   output logic signed [hbridge_pkg::SAMPLE_W-1:0] o_adc_a,
   output logic signed [hbridge_pkg::SAMPLE_W-1:0] o_adc_b,
   output logic        [hbridge_pkg::SAMPLE_W-1:0] o_da,
   output logic        [hbridge_pkg::SAMPLE_W-1:0] o_db,
   output logic        [hbridge_pkg::N_SWITCH-1:0] o_gate,
   output logic                                   o_converter_on,
   output logic        [hbridge_pkg::ANGLE_W-1:0]  o_phi,
   output logic        [hbridge_pkg::ANGLE_W-1:0]  o_delta,
   output logic        [7:0]                      o_seg0,
   output logic        [7:0]                      o_seg1
);
   import hbridge_pkg::*;

   // sw[3] low edits phi, high edits delta
   logic                sel_delta;
   logic [N_SWITCH-1:0] delayed;
   logic [7:0]          phi_ones;
   logic [7:0]          phi_tens;
   logic [7:0]          delta_ones;
   logic [7:0]          delta_tens;

   assign sel_delta = i_sw[3];

   // ==================================================
   // tank samples
   // ==================================================
   sample_capture u_capture (
      .ADA_DCO    (ADA_DCO),    .i_rst_n    (i_rst_n),
      .i_ada_data (i_ada_data), .i_adb_data (i_adb_data),
      .o_adc_a    (o_adc_a),    .o_adc_b    (o_adc_b),
      .o_da       (o_da),       .o_db       (o_db)
   );

   // ==================================================
   // gate path
   // ==================================================
   dead_time u_dead_time (
      .ADA_DCO (ADA_DCO), .i_rst_n (i_rst_n),
      .i_cmd   (i_bridge_cmd), .i_dt_sel (i_dsw_dt), .o_delayed (delayed)
   );

   // sw[0] enables the bridge
   bridge_sequencer u_sequencer (
      .ADA_DCO   (ADA_DCO), .i_rst_n (i_rst_n), .i_enable (i_sw[0]),
      .i_delayed (delayed), .o_gate  (o_gate),  .o_converter_on (o_converter_on)
   );

   // ==================================================
   // setpoints, buttons only reach the selected one
   // ==================================================
   // button 1 up, button 2 down, button 0 zero
   angle_setpoint #(.STEP(PHI_STEP), .MAX(PHI_MAX)) u_phi (
      .ADA_DCO (ADA_DCO), .i_rst_n (i_rst_n),
      .i_inc   (i_button[1] & ~sel_delta), .i_dec (i_button[2] & ~sel_delta),
      .i_zero  (i_button[0] & ~sel_delta), .o_value (o_phi),
      .o_seg_ones (phi_ones), .o_seg_tens (phi_tens)
   );

   angle_setpoint #(.STEP(DELTA_STEP), .MAX(DELTA_MAX)) u_delta (
      .ADA_DCO (ADA_DCO), .i_rst_n (i_rst_n),
      .i_inc   (i_button[1] & sel_delta), .i_dec (i_button[2] & sel_delta),
      .i_zero  (i_button[0] & sel_delta), .o_value (o_delta),
      .o_seg_ones (delta_ones), .o_seg_tens (delta_tens)
   );

   // display follows the edited setpoint
   assign o_seg0 = sel_delta ? delta_ones : phi_ones;
   assign o_seg1 = sel_delta ? delta_tens : phi_tens;

endmodule

// ==== dv/converter_properties.sv ====
`timescale 1ns/1ps

module converter_properties (
   input logic                               ADA_DCO,
   input logic                               i_rst_n,
   input logic [3:0]                         i_sw,
   input logic [hbridge_pkg::N_SWITCH-1:0]   o_gate,
   input logic [hbridge_pkg::ANGLE_W-1:0]    o_phi,
   input logic [hbridge_pkg::ANGLE_W-1:0]    o_delta
);
   import hbridge_pkg::*;

   // ==================================================
   // gate safety
   // ==================================================
   // high and low side of one leg never on together
   leg_short_a: assert property (@(posedge ADA_DCO) disable iff (!i_rst_n)
      !((o_gate[0] && o_gate[2]) || (o_gate[1] && o_gate[3])))
      else $error("leg short on gates %b", o_gate);

   // enable low clears all gates one cycle later
   gates_off_a: assert property (@(posedge ADA_DCO) disable iff (!i_rst_n)
      !i_sw[0] |=> (o_gate == '0))
      else $error("gates %b still on after enable dropped", o_gate);

   // setpoints stay inside their range
   phi_range_a: assert property (@(posedge ADA_DCO) disable iff (!i_rst_n)
      o_phi <= PHI_MAX)
      else $error("phi %0d above its maximum", o_phi);

   delta_range_a: assert property (@(posedge ADA_DCO) disable iff (!i_rst_n)
      o_delta <= DELTA_MAX)
      else $error("delta %0d above its maximum", o_delta);

endmodule

// ==== dv/converter_monitor.sv ====
`timescale 1ns/1ps

module converter_monitor (
   input  logic                                    ADA_DCO,
   input  logic                                    i_rst_n,
   input  logic signed [hbridge_pkg::SAMPLE_W-1:0] i_ada_data,
   input  logic signed [hbridge_pkg::SAMPLE_W-1:0] i_adb_data,
   input  logic        [hbridge_pkg::N_SWITCH-1:0] i_bridge_cmd,
   input  logic        [3:0]                       i_sw,
   input  logic        [3:0]                       i_button,
   input  logic        [hbridge_pkg::DT_SEL_W-1:0] i_dsw_dt,
   input  logic signed [hbridge_pkg::SAMPLE_W-1:0] o_adc_a,
   input  logic signed [hbridge_pkg::SAMPLE_W-1:0] o_adc_b,
   input  logic        [hbridge_pkg::SAMPLE_W-1:0] o_da,
   input  logic        [hbridge_pkg::SAMPLE_W-1:0] o_db,
   input  logic        [hbridge_pkg::N_SWITCH-1:0] o_gate,
   input  logic                                    o_converter_on,
   input  logic        [hbridge_pkg::ANGLE_W-1:0]  o_phi,
   input  logic        [hbridge_pkg::ANGLE_W-1:0]  o_delta,
   input  logic        [7:0]                       o_seg0,
   input  logic        [7:0]                       o_seg1,
   output int                                      o_errors
);
   import hbridge_pkg::*;

   int                  err_count = 0;
   logic                armed = 1'b0;
   // model state, updated on the rising edge
   logic [SAMPLE_W-1:0] m_adc_a;
   logic [SAMPLE_W-1:0] m_adc_b;
   logic [SAMPLE_W-1:0] m_da;
   logic [SAMPLE_W-1:0] m_db;
   int                  m_phi;
   int                  m_delta;
   logic [2:0]          prev_phi_btn;
   logic [2:0]          prev_delta_btn;
   int                  run_len [N_SWITCH];
   logic [N_SWITCH-1:0] m_dly;
   logic [N_SWITCH-1:0] m_gate;
   logic                m_on;
   int                  en_cyc;

   assign o_errors = err_count;

   // ==================================================
   // reference functions
   // ==================================================
   function automatic logic [SAMPLE_W-1:0] neg_ref(input logic signed [SAMPLE_W-1:0] s);
      return SAMPLE_W'(-int'(s));
   endfunction

   // negated sample moved to mid scale
   function automatic logic [SAMPLE_W-1:0] dac_ref(input logic signed [SAMPLE_W-1:0] s);
      return SAMPLE_W'(8191 - int'(s));
   endfunction

   // edges: bit 0 zero, bit 1 up, bit 2 down
   function automatic int step_value(input int v, input logic [2:0] edges,
                                     input int step, input int max);
      if (edges[0]) return 0;
      if (edges[1]) return (v + step > max) ? max : v + step;
      if (edges[2]) return (v < step) ? 0 : v - step;
      return v;
   endfunction

   function automatic int dt_cycles(input logic [1:0] sel);
      case (sel)
         2'b00:   return 8;
         2'b01:   return 4;
         2'b10:   return 2;
         default: return 6;
      endcase
   endfunction

   function automatic logic [N_SWITCH-1:0] gate_ref(input logic en, input int ticks,
                                                    input logic [N_SWITCH-1:0] dly);
      if (!en) return '0;
      if (ticks <= ON_TICKS) return 4'b1100;
      if (ticks <= VG_TICKS) return 4'b1001;
      // shorted leg blocks everything
      if ((dly[0] && dly[2]) || (dly[1] && dly[3])) return '0;
      return dly;
   endfunction

   // active low, dot off
   function automatic logic [7:0] seg_ref(input int d);
      case (d)
         0:       return 8'hc0;
         1:       return 8'hf9;
         2:       return 8'ha4;
         3:       return 8'hb0;
         4:       return 8'h99;
         5:       return 8'h92;
         6:       return 8'h82;
         7:       return 8'hf8;
         8:       return 8'h80;
         default: return 8'h90;
      endcase
   endfunction

   task automatic check(input string name, input logic [SAMPLE_W-1:0] act,
                        input logic [SAMPLE_W-1:0] exp);
      if (act !== exp) begin
         $display("ERR t=%0d ns %s expected %h actual %h", $time, name, exp, act);
         err_count++;
      end
   endtask

   // ==================================================
   // cycle model, same inputs the dut samples
   // ==================================================
   always @(posedge ADA_DCO) begin
      logic [2:0]          pb;
      logic [2:0]          db;
      logic [N_SWITCH-1:0] nd;
      int                  ticks;
      pb = i_button[2:0] & {3{~i_sw[3]}};
      db = i_button[2:0] & {3{i_sw[3]}};
      // start-up ticks so far, frozen past the forced phase
      ticks = en_cyc / TICK_CYCLES;
      if (ticks > VG_TICKS + 1) ticks = VG_TICKS + 1;
      armed = 1'b1;
      if (!i_rst_n) begin
         m_adc_a = '0;
         m_adc_b = '0;
         m_da = '0;
         m_db = '0;
         m_phi = 0;
         m_delta = 0;
         prev_phi_btn = '0;
         prev_delta_btn = '0;
         for (int i = 0; i < N_SWITCH; i++) run_len[i] = 0;
         m_dly = '0;
         m_gate = '0;
         m_on = 1'b0;
         en_cyc = 0;
      end else begin
         m_adc_a = neg_ref(i_ada_data);
         m_adc_b = neg_ref(i_adb_data);
         m_da = dac_ref(i_ada_data);
         m_db = dac_ref(i_adb_data);
         m_phi = step_value(m_phi, pb & ~prev_phi_btn, 5, 90);
         m_delta = step_value(m_delta, db & ~prev_delta_btn, 1, 40);
         prev_phi_btn = pb;
         prev_delta_btn = db;
         // gates use the delayed pattern from before this edge
         m_gate = gate_ref(i_sw[0], ticks, m_dly);
         m_on = i_sw[0] && ticks > ON_TICKS;
         for (int i = 0; i < N_SWITCH; i++) begin
            nd[i] = i_bridge_cmd[i] && (m_dly[i] || run_len[i] >= dt_cycles(i_dsw_dt));
            run_len[i] = i_bridge_cmd[i] ? run_len[i] + 1 : 0;
         end
         m_dly = nd;
         en_cyc = i_sw[0] ? en_cyc + 1 : 0;
      end
   end

   // compare away from the rising edge
   always @(negedge ADA_DCO) begin
      if (armed) begin
         check("o_adc_a", o_adc_a, m_adc_a);
         check("o_adc_b", o_adc_b, m_adc_b);
         check("o_da", o_da, m_da);
         check("o_db", o_db, m_db);
         check("o_gate", o_gate, m_gate);
         check("o_converter_on", o_converter_on, m_on);
         check("o_phi", o_phi, SAMPLE_W'(m_phi));
         check("o_delta", o_delta, SAMPLE_W'(m_delta));
         check("o_seg0", o_seg0, seg_ref(i_sw[3] ? m_delta % 10 : m_phi % 10));
         check("o_seg1", o_seg1, seg_ref(i_sw[3] ? m_delta / 10 : m_phi / 10));
      end
   end

endmodule

// ==== dv/tb_converter.sv ====
`timescale 1ns/1ps

module tb_converter;
   import hbridge_pkg::*;

   logic                       ADA_DCO;
   logic                       i_rst_n;
   logic signed [SAMPLE_W-1:0] i_ada_data;
   logic signed [SAMPLE_W-1:0] i_adb_data;
   logic [N_SWITCH-1:0]        i_bridge_cmd;
   logic [3:0]                 i_sw;
   logic [3:0]                 i_button;
   logic [DT_SEL_W-1:0]        i_dsw_dt;
   logic signed [SAMPLE_W-1:0] o_adc_a;
   logic signed [SAMPLE_W-1:0] o_adc_b;
   logic [SAMPLE_W-1:0]        o_da;
   logic [SAMPLE_W-1:0]        o_db;
   logic [N_SWITCH-1:0]        o_gate;
   logic                       o_converter_on;
   logic [ANGLE_W-1:0]         o_phi;
   logic [ANGLE_W-1:0]         o_delta;
   logic [7:0]                 o_seg0;
   logic [7:0]                 o_seg1;
   int                         mon_errors;
   logic [31:0]                lfsr_state;
   int                         timeouts;
   int                         tests_run;
   int                         tests_failed;
   int                         seen_bad;

   converter_top i_dut (.*);
   converter_monitor u_monitor (.*, .o_errors(mon_errors));

   bind converter_top converter_properties u_props (
      .ADA_DCO (ADA_DCO), .i_rst_n (i_rst_n), .i_sw (i_sw),
      .o_gate  (o_gate),  .o_phi   (o_phi),   .o_delta (o_delta)
   );

   // 100 ns period
   always #50 ADA_DCO = ~ADA_DCO;

   // ==================================================
   // stimulus helpers
   // ==================================================
   // taps 32 22 2 1
   // one step per bit
   function automatic logic [31:0] take_bits(input int n);
      logic [31:0] r;
      logic        fb;
      r = '0;
      for (int k = 0; k < n; k++) begin
         fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
         lfsr_state = {lfsr_state[30:0], fb};
         r = {r[30:0], fb};
      end
      return r;
   endfunction

   task automatic cycles(input int n);
      repeat (n) @(posedge ADA_DCO);
   endtask

   task automatic press(input int btn);
      @(posedge ADA_DCO);
      i_button[btn] <= 1'b1;
      cycles(2);
      i_button[btn] <= 1'b0;
      cycles(2);
   endtask

   task automatic wait_converter_on(input int limit);
      int n;
      n = 0;
      while (o_converter_on !== 1'b1 && n < limit) begin
         @(negedge ADA_DCO);
         n++;
      end
      if (o_converter_on !== 1'b1) begin
         $display("timeout: o_converter_on did not rise within %0d cycles", limit);
         timeouts++;
      end
   endtask

   // one line per test with the problems since the last one
   task automatic end_test(input string name);
      int fresh;
      fresh = mon_errors + timeouts - seen_bad;
      seen_bad = mon_errors + timeouts;
      tests_run++;
      if (fresh != 0) tests_failed++;
      $display("test %0d %s: %s (%0d problems)", tests_run, name,
               (fresh == 0) ? "ok" : "FAILED", fresh);
   endtask

   // ==================================================
   // test sequence
   // ==================================================
   initial begin
      int hold;
      ADA_DCO      = 1'b0;
      i_rst_n      = 1'b0;
      i_ada_data   = '0;
      i_adb_data   = '0;
      i_bridge_cmd = '0;
      i_sw         = '0;
      i_button     = '0;
      i_dsw_dt     = '0;
      lfsr_state   = 32'hf733;
      timeouts     = 0;
      tests_run    = 0;
      tests_failed = 0;
      seen_bad     = 0;

      cycles(8);
      i_rst_n <= 1'b1;
      cycles(2);
      end_test("reset values");

      repeat (200) begin
         @(posedge ADA_DCO);
         i_ada_data <= SAMPLE_W'(take_bits(SAMPLE_W));
         i_adb_data <= SAMPLE_W'(take_bits(SAMPLE_W));
      end
      cycles(2);
      end_test("sample capture");

      // phi up to its limit and down to zero
      repeat (20) press(1);
      repeat (20) press(2);
      // phi left at 15 while delta moves
      repeat (3) press(1);
      @(posedge ADA_DCO);
      i_sw[3] <= 1'b1;
      repeat (45) press(1);
      repeat (5) press(2);
      press(0);
      // delta left at 2 while phi is cleared
      repeat (2) press(1);
      @(posedge ADA_DCO);
      i_sw[3] <= 1'b0;
      press(0);
      repeat (4) press(1);
      end_test("setpoints");

      @(posedge ADA_DCO);
      i_sw[0] <= 1'b1;
      wait_converter_on(200);
      // drop enable in the forced phase and restart
      cycles(4);
      i_sw[0] <= 1'b0;
      cycles(6);
      i_sw[0] <= 1'b1;
      wait_converter_on(200);
      cycles(40);
      end_test("start-up sequence");

      for (int sel = 0; sel < 4; sel++) begin
         @(posedge ADA_DCO);
         i_dsw_dt <= DT_SEL_W'(sel);
         repeat (30) begin
            hold = int'(take_bits(4));
            @(posedge ADA_DCO);
            i_bridge_cmd <= N_SWITCH'(take_bits(N_SWITCH));
            cycles(hold);
         end
         i_bridge_cmd <= '0;
         cycles(12);
      end
      end_test("dead time and blocking");

      $display("%0d tests, %0d failed, %0d mismatches, %0d timeouts",
               tests_run, tests_failed, mon_errors, timeouts);
      if (mon_errors == 0 && timeouts == 0) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   end

endmodule

// ==== filelist.f ====
src/hbridge_pkg.sv
src/sample_capture.sv
src/dead_time.sv
src/bridge_sequencer.sv
src/angle_setpoint.sv
src/converter_top.sv
dv/converter_properties.sv
dv/converter_monitor.sv
dv/tb_converter.sv

// ==== Makefile ====
SIM      := verilator
FLAGS    := --binary --timing --assert -Wno-fatal
TOP      := tb_converter
FILELIST := filelist.f
BUILD    := obj_dir
LOG      := sim.log
PASS_MSG := Finished with no errors

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with $(SIM), run $(TOP), check $(LOG)"
	@echo "  clean  remove $(BUILD) and $(LOG)"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
